/* include/commu_macros.svh */
// build-time sizes for the receive buffer; COMMU_SWAP_DLY must be at least 2, frames fit one bank
`ifndef COMMU_MACROS_SVH
`define COMMU_MACROS_SVH

// ---------------------------------------------------------------------------
// buffer geometry
// ---------------------------------------------------------------------------

// byte address width of one bank, 2**AW bytes per bank
`define COMMU_BUF_AW 10

// ---------------------------------------------------------------------------
// timing
// ---------------------------------------------------------------------------

// cycles from frame end to bank swap
`define COMMU_SWAP_DLY 8

// upper bound on one req/ack phase, in clk_sys cycles
`define COMMU_HS_TIMEOUT 2000

`endif

/* hdl/commu_pkg.sv */
// shared types for the receive buffer; widths follow COMMU_BUF_AW from the macros header
`include "commu_macros.svh"

package commu_pkg;

	// -----------------------------------------------------------------------
	// data path records
	// -----------------------------------------------------------------------

	// byte address inside one bank
	typedef logic [`COMMU_BUF_AW-1:0] buf_addr_t;

	// repacker to buffer, high byte first on the line
	typedef struct packed {
		logic [15:0] data;
		logic        vld;
		logic        frm;
	} repk_word_t;

	// reader to buffer
	typedef struct packed {
		logic rd;
		logic frm;
	} rd_ctl_t;

	// frame report, len counts bytes and can equal the bank size
	typedef struct packed {
		logic                  rdy;
		logic [`COMMU_BUF_AW:0] len;
	} frm_rdy_t;

	// -----------------------------------------------------------------------
	// encodings
	// -----------------------------------------------------------------------

	// bank taken by the writer
	typedef enum logic {BANK_A, BANK_B} bank_t;

	typedef enum logic [1:0] {RX_IDLE, RX_HI, RX_LO, RX_WAIT} rx_state_t;

	typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_REQ, RD_ACK} rd_state_t;

endpackage

/* hdl/commu_dpram.sv */
// behavioural byte-wide simple dual-port bank; read of a same-cycle write returns the old byte
`timescale 1ns/1ps
`include "commu_macros.svh"

module commu_dpram import commu_pkg::*; (
	input  logic       clk_sys,
	input  logic       wr_en,
	input  buf_addr_t  wr_addr,
	input  logic [7:0] wr_data,
	input  buf_addr_t  rd_addr,
	output logic [7:0] rd_data
);

	localparam int DEPTH = 1 << `COMMU_BUF_AW;

	logic [7:0] mem [0:DEPTH-1];

	// write port
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read, one cycle after the address
	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_addr];
	end

endmodule

/* hdl/commu_repack.sv */
// four-phase byte sink pairing bytes into words; frames are even length, in_last sits on a low byte
`timescale 1ns/1ps

module commu_repack import commu_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       in_req,
	input  logic [7:0] in_byte,
	input  logic       in_last,
	output logic       in_ack,
	input  logic       buf_full,
	output repk_word_t word
);

	rx_state_t   state;
	logic        hi_held;
	logic        last_q;
	logic        take;
	logic [7:0]  hi_byte;
	logic [15:0] word_data;
	logic        word_vld;
	logic        word_frm;

	// a new frame only starts when the buffer has room
	assign take = in_req && ((state == RX_IDLE && !buf_full) ||
		state == RX_HI || state == RX_LO);

	assign word = '{data: word_data, vld: word_vld, frm: word_frm};

	// ------------------------------------------------------------------------
	// handshake and framing
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state    <= RX_IDLE;
			in_ack   <= 1'b0;
			hi_held  <= 1'b0;
			last_q   <= 1'b0;
			word_vld <= 1'b0;
			word_frm <= 1'b0;
		end else begin
			word_vld <= 1'b0;
			// frame closes one cycle after the last word
			if (word_vld && last_q) begin
				word_frm <= 1'b0;
			end
			case (state)
				RX_IDLE, RX_HI: begin
					if (take) begin
						in_ack  <= 1'b1;
						hi_held <= 1'b1;
						state   <= RX_WAIT;
					end
				end
				RX_LO: begin
					if (take) begin
						in_ack   <= 1'b1;
						hi_held  <= 1'b0;
						last_q   <= in_last;
						word_vld <= 1'b1;
						word_frm <= 1'b1;
						state    <= RX_WAIT;
					end
				end
				RX_WAIT: begin
					// release ack only once the source has dropped req
					if (!in_req) begin
						in_ack <= 1'b0;
						if (hi_held) begin
							state <= RX_LO;
						end else if (last_q) begin
							state <= RX_IDLE;
						end else begin
							state <= RX_HI;
						end
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// byte capture
	always_ff @(posedge clk_sys) begin
		if (take && state != RX_LO) begin
			hi_byte <= in_byte;
		end
		if (take && state == RX_LO) begin
			word_data <= {hi_byte, in_byte};
		end
	end

endmodule

/* hdl/commu_m_buf.sv */
// ping-pong frame buffer; COMMU_SWAP_DLY >= 2, a swap waits for rd_done, buf_full also covers the swap delay
`timescale 1ns/1ps
`include "commu_macros.svh"

module commu_m_buf import commu_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  repk_word_t word,
	input  rd_ctl_t    rd_ctl,
	input  logic       rd_done,
	output logic [7:0] buf_q,
	output frm_rdy_t   frm_rdy,
	output logic       buf_full
);

	localparam int SWAP_LAST = `COMMU_SWAP_DLY - 1;
	localparam int SWAP_CW   = $clog2(`COMMU_SWAP_DLY + 1);

	bank_t                  wr_bank;
	logic                   frm_q;
	logic                   frm_fall;
	logic                   vld_q;
	logic                   wren;
	logic                   wren_a;
	logic                   wren_b;
	logic [`COMMU_BUF_AW:0] wr_cnt;
	logic [`COMMU_BUF_AW:0] len_q;
	buf_addr_t              wr_addr;
	buf_addr_t              rd_addr;
	logic [7:0]             wr_data;
	logic [7:0]             q_a;
	logic [7:0]             q_b;
	logic                   swap_pend;
	logic                   swap_go;
	logic                   rd_busy;
	logic                   rdy_q;
	logic [SWAP_CW-1:0]     swap_cnt;

	// ------------------------------------------------------------------------
	// frame end and bank swap
	// ------------------------------------------------------------------------
	assign frm_fall = frm_q && !word.frm;

	// the reader must be done with the other bank first
	assign swap_go = swap_pend && !rd_busy && (swap_cnt == SWAP_CW'(SWAP_LAST));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			frm_q     <= 1'b0;
			swap_pend <= 1'b0;
			swap_cnt  <= '0;
		end else begin
			frm_q <= word.frm;
			if (frm_fall) begin
				swap_pend <= 1'b1;
				swap_cnt  <= SWAP_CW'(1);
			end else if (swap_go) begin
				swap_pend <= 1'b0;
			end else if (swap_pend && swap_cnt != SWAP_CW'(SWAP_LAST)) begin
				swap_cnt <= swap_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_bank <= BANK_A;
			rd_busy <= 1'b0;
			rdy_q   <= 1'b0;
		end else begin
			rdy_q <= swap_go;
			if (swap_go) begin
				wr_bank <= (wr_bank == BANK_A) ? BANK_B : BANK_A;
				rd_busy <= 1'b1;
			end else if (rd_done) begin
				rd_busy <= 1'b0;
			end
		end
	end

	// byte count of the finished frame, stable until the next frame ends
	// the low byte of the last word is still being written when frm falls
	always_ff @(posedge clk_sys) begin
		if (frm_fall) begin
			len_q <= wr_cnt + 1'b1;
		end
	end

	assign frm_rdy  = '{rdy: rdy_q, len: len_q};
	assign buf_full = swap_pend;

	// ------------------------------------------------------------------------
	// write path
	// ------------------------------------------------------------------------
	assign wren    = word.vld || vld_q;
	assign wren_a  = wren && (wr_bank == BANK_A);
	assign wren_b  = wren && (wr_bank == BANK_B);
	// high byte on vld, low byte on its echo
	assign wr_data = word.vld ? word.data[15:8] : word.data[7:0];
	assign wr_addr = wr_cnt[`COMMU_BUF_AW-1:0];

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			vld_q  <= 1'b0;
			wr_cnt <= '0;
		end else begin
			vld_q <= word.vld;
			if (wren) begin
				wr_cnt <= wr_cnt + 1'b1;
			end else if (!word.frm) begin
				wr_cnt <= '0;
			end
		end
	end

	// ------------------------------------------------------------------------
	// read path
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rd_addr <= '0;
		end else if (rd_ctl.rd) begin
			rd_addr <= rd_addr + 1'b1;
		end else if (!rd_ctl.frm) begin
			rd_addr <= '0;
		end
	end

	// always read the bank the writer is not using
	assign buf_q = (wr_bank == BANK_A) ? q_b : q_a;

	commu_dpram i_bank_a (
		.clk_sys (clk_sys),
		.wr_en   (wren_a),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (q_a)
	);

	commu_dpram i_bank_b (
		.clk_sys (clk_sys),
		.wr_en   (wren_b),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (q_b)
	);

endmodule

/* hdl/commu_rd_ctl.sv */
// frame reader and four-phase byte source; frame length from frm_rdy must be nonzero
`timescale 1ns/1ps
`include "commu_macros.svh"

module commu_rd_ctl import commu_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  frm_rdy_t   frm_rdy,
	output rd_ctl_t    rd_ctl,
	output logic       rd_done,
	input  logic [7:0] buf_q,
	output logic       out_req,
	output logic [7:0] out_byte,
	input  logic       out_ack,
	output logic       out_last
);

	rd_state_t              state;
	logic [`COMMU_BUF_AW:0] len_q;
	logic [`COMMU_BUF_AW:0] cnt_q;
	logic                   rd_q;
	logic                   rfrm_q;
	logic                   last_byte;

	assign rd_ctl    = '{rd: rd_q, frm: rfrm_q};
	assign last_byte = (cnt_q + 1'b1) == len_q;

	// ------------------------------------------------------------------------
	// read sequencer
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state    <= RD_IDLE;
			cnt_q    <= '0;
			rd_q     <= 1'b0;
			rfrm_q   <= 1'b0;
			rd_done  <= 1'b0;
			out_req  <= 1'b0;
			out_last <= 1'b0;
		end else begin
			rd_done <= 1'b0;
			case (state)
				RD_IDLE: begin
					if (frm_rdy.rdy) begin
						cnt_q  <= '0;
						rfrm_q <= 1'b1;
						rd_q   <= 1'b1;
						state  <= RD_ADDR;
					end
				end
				RD_ADDR: begin
					// first cycle drops rd, second sees the ram data
					if (rd_q) begin
						rd_q <= 1'b0;
					end else begin
						out_last <= last_byte;
						out_req  <= 1'b1;
						state    <= RD_REQ;
					end
				end
				RD_REQ: begin
					if (out_ack) begin
						out_req <= 1'b0;
						cnt_q   <= cnt_q + 1'b1;
						state   <= RD_ACK;
					end
				end
				RD_ACK: begin
					if (!out_ack) begin
						if (cnt_q == len_q) begin
							rd_done <= 1'b1;
							rfrm_q  <= 1'b0;
							state   <= RD_IDLE;
						end else begin
							rd_q  <= 1'b1;
							state <= RD_ADDR;
						end
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clk_sys) begin
		if (state == RD_IDLE && frm_rdy.rdy) begin
			len_q <= frm_rdy.len;
		end
		if (state == RD_ADDR && !rd_q) begin
			out_byte <= buf_q;
		end
	end

endmodule

/* hdl/commu_m_top.sv */
// receive buffer top; both req/ack ports are four-phase and run on clk_sys
`timescale 1ns/1ps

module commu_m_top import commu_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	// byte input
	input  logic       in_req,
	input  logic [7:0] in_byte,
	input  logic       in_last,
	output logic       in_ack,
	// byte output
	output logic       out_req,
	output logic [7:0] out_byte,
	output logic       out_last,
	input  logic       out_ack
);

	repk_word_t word;
	frm_rdy_t   frm_rdy;
	rd_ctl_t    rd_ctl;
	logic       buf_full;
	logic       rd_done;
	logic [7:0] buf_q;

	commu_repack i_repack (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.in_req   (in_req),
		.in_byte  (in_byte),
		.in_last  (in_last),
		.in_ack   (in_ack),
		.buf_full (buf_full),
		.word     (word)
	);

	commu_m_buf i_buf (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.word     (word),
		.rd_ctl   (rd_ctl),
		.rd_done  (rd_done),
		.buf_q    (buf_q),
		.frm_rdy  (frm_rdy),
		.buf_full (buf_full)
	);

	commu_rd_ctl i_rd_ctl (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.frm_rdy  (frm_rdy),
		.rd_ctl   (rd_ctl),
		.rd_done  (rd_done),
		.buf_q    (buf_q),
		.out_req  (out_req),
		.out_byte (out_byte),
		.out_ack  (out_ack),
		.out_last (out_last)
	);

endmodule

/* tb/commu_m_chk.sv */
// handshake and reset checks bound into the receive buffer top; failures only count and call $error
`timescale 1ns/1ps

module commu_m_chk (
	input logic       clk_sys,
	input logic       rst_n,
	input logic       in_req,
	input logic       in_last,
	input logic       in_ack,
	input logic       out_req,
	input logic [7:0] out_byte,
	input logic       out_last,
	input logic       out_ack,
	input logic       buf_full
);

	int   fail_cnt;
	logic seen_req;
	logic ack_q;
	logic at_start;

	initial fail_cnt = 0;

	// frame position on the input side, set when the previous byte was last
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			seen_req <= 1'b0;
			ack_q    <= 1'b0;
			at_start <= 1'b1;
		end else begin
			ack_q <= in_ack;
			if (in_req) begin
				seen_req <= 1'b1;
			end
			if (in_ack && !ack_q) begin
				at_start <= in_last;
			end
		end
	end

	// ------------------------------------------------------------------------
	// reset state
	// ------------------------------------------------------------------------
	a_reset_idle: assert property (@(posedge clk_sys)
		$rose(rst_n) |-> !in_ack && !out_req && !buf_full)
		else begin $error("handshakes busy after reset"); fail_cnt++; end

	a_quiet_start: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!seen_req |-> !in_ack && !out_req)
		else begin $error("handshake active before first request"); fail_cnt++; end

	// ------------------------------------------------------------------------
	// four-phase order
	// ------------------------------------------------------------------------
	a_in_ack_rise: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(in_ack) |-> $past(in_req))
		else begin $error("in_ack rose without in_req"); fail_cnt++; end

	a_in_ack_fall: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$fell(in_ack) |-> $past(!in_req))
		else begin $error("in_ack fell before in_req"); fail_cnt++; end

	a_out_stable: assert property (@(posedge clk_sys) disable iff (!rst_n)
		out_req && $past(out_req) |-> $stable(out_byte) && $stable(out_last))
		else begin $error("out payload moved under out_req"); fail_cnt++; end

	a_out_req_rise: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(out_req) |-> $past(!out_ack))
		else begin $error("out_req rose with out_ack high"); fail_cnt++; end

	a_out_req_fall: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$fell(out_req) |-> $past(out_ack))
		else begin $error("out_req fell without out_ack"); fail_cnt++; end

	// no new frame accepted while both banks are taken
	a_full_stall: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(in_ack) && at_start |-> !$past(buf_full))
		else begin $error("frame accepted while buffer full"); fail_cnt++; end

endmodule

/* tb/tb_commu_m.sv */
// testbench for the receive buffer; needs the bound checker, frames are even length and fit one bank
`timescale 1ns/1ps
`include "commu_macros.svh"

module tb_commu_m;

	localparam int MAX_LEN   = 1 << `COMMU_BUF_AW;
	localparam int N_RAND    = 12;
	localparam int N_SLOW    = 3;
	localparam int N_FRM     = N_RAND + N_SLOW + 2;
	localparam int WD_CYCLES = N_FRM * (MAX_LEN * 20 + 200);

	logic       clk_sys;
	logic       rst_n;
	logic       in_req;
	logic [7:0] in_byte;
	logic       in_last;
	logic       in_ack;
	logic       out_req;
	logic [7:0] out_byte;
	logic       out_last;
	logic       out_ack;

	// expected stream, bit 8 is the last-byte flag
	logic [8:0] exp_q[$];
	int         err_cnt;

	commu_m_top i_dut (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.in_req   (in_req),
		.in_byte  (in_byte),
		.in_last  (in_last),
		.in_ack   (in_ack),
		.out_req  (out_req),
		.out_byte (out_byte),
		.out_last (out_last),
		.out_ack  (out_ack)
	);

	bind commu_m_top commu_m_chk i_chk (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.in_req   (in_req),
		.in_last  (in_last),
		.in_ack   (in_ack),
		.out_req  (out_req),
		.out_byte (out_byte),
		.out_last (out_last),
		.out_ack  (out_ack),
		.buf_full (buf_full)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ------------------------------------------------------------------------
	// byte source and sink
	// ------------------------------------------------------------------------
	task automatic send_frame(input int len);
		logic [7:0] b;
		for (int i = 0; i < len; i++) begin
			b = 8'($urandom);
			exp_q.push_back({i == len - 1, b});
			@(posedge clk_sys);
			in_byte <= b;
			in_last <= (i == len - 1);
			in_req  <= 1'b1;
			do @(posedge clk_sys); while (!in_ack);
			in_req <= 1'b0;
			do @(posedge clk_sys); while (in_ack);
		end
	endtask

	task automatic receive_bytes(input int n, input bit slow);
		int         dly;
		logic [8:0] want;
		for (int k = 0; k < n; k++) begin
			do @(posedge clk_sys); while (!out_req);
			dly = slow ? 6 : $urandom_range(6, 0);
			repeat (dly) @(posedge clk_sys);
			if (exp_q.size() == 0) begin
				err_cnt++;
				$display("output byte %02h at %0t arrived with nothing left to expect",
					out_byte, $time);
			end else begin
				want = exp_q.pop_front();
				if (out_byte !== want[7:0] || out_last !== want[8]) begin
					err_cnt++;
					$display("ERR %0t: expected byte %02h last %0b, got byte %02h last %0b",
						$time, want[7:0], want[8], out_byte, out_last);
				end
			end
			out_ack <= 1'b1;
			do @(posedge clk_sys); while (out_req);
			out_ack <= 1'b0;
		end
	endtask

	// frames go in back to back while the sink drains them
	task automatic run_phase(input int nfrm, input int min_len, input int max_len,
		input bit slow);
		int lens[$];
		int total;
		total = 0;
		for (int f = 0; f < nfrm; f++) begin
			lens.push_back(2 * $urandom_range(max_len / 2, min_len / 2));
			total += lens[f];
		end
		fork
			begin
				foreach (lens[f]) begin
					send_frame(lens[f]);
				end
			end
			receive_bytes(total, slow);
		join
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		err_cnt = 0;
		void'($urandom(45461));
		rst_n   <= 1'b0;
		in_req  <= 1'b0;
		in_byte <= 8'h00;
		in_last <= 1'b0;
		out_ack <= 1'b0;
		repeat (4) @(posedge clk_sys);
		rst_n <= 1'b1;
		// quiet stretch before the first request
		repeat (10) @(posedge clk_sys);
		run_phase(N_RAND, 2, 64, 1'b0);
		// slowest sink forces the second bank and the input stall
		run_phase(N_SLOW, 32, 96, 1'b1);
		run_phase(1, 2, 2, 1'b0);
		run_phase(1, MAX_LEN, MAX_LEN, 1'b0);
		repeat (20) @(posedge clk_sys);
		if (exp_q.size() != 0) begin
			err_cnt++;
			$display("%0d input bytes never came out", exp_q.size());
		end
		$display("errors: scoreboard %0d, assertions %0d", err_cnt, i_dut.i_chk.fail_cnt);
		if (err_cnt == 0 && i_dut.i_chk.fail_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (WD_CYCLES) @(posedge clk_sys);
		$display("timeout: the run did not finish within %0d clock cycles", WD_CYCLES);
		$display("Some tests failed");
		$finish;
	end

endmodule

/* all.f */
+incdir+include
hdl/commu_pkg.sv
hdl/commu_dpram.sv
hdl/commu_repack.sv
hdl/commu_m_buf.sv
hdl/commu_rd_ctl.sv
hdl/commu_m_top.sv
tb/commu_m_chk.sv
tb/tb_commu_m.sv

/* run.sh */
#!/bin/sh
# build and run the receive buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_commu_m -f all.f -Mdir obj_dir -o tb_commu_m > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/tb_commu_m +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
	exit 1
fi
exit 0
